//--- src/vec_pkg.sv
package vec_pkg;

    ////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////

    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;
    // Wide enough to hold vl = VLEN (SEW 8, LMUL 8)
    localparam int VL_W  = 7;

    ////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        VNOP     = 4'h0,
        VSETVLI  = 4'h1,
        VSETIVLI = 4'h2,
        VADD     = 4'h3,
        VSUB     = 4'h4,
        VAND     = 4'h5,
        VOR      = 4'h6,
        VXOR     = 4'h7,
        VMIN     = 4'h8,
        VMAX     = 4'h9,
        VSLL     = 4'hA,
        VSRL     = 4'hB,
        VMV_V    = 4'hC,
        VMV_S_X  = 4'hD,
        VMV_X_S  = 4'hE
    } vec_op_e;

    // funct3 categories
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPMVX = 3'b110
    } op_cat_e;

    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vsew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    typedef enum logic [1:0] {
        V_IDLE  = 2'b00,
        V_EXEC  = 2'b01,
        V_DRAIN = 2'b10
    } vec_state_e;

    ////////////////////////////////////////
    // Structures
    ////////////////////////////////////////

    // Same bit order as the vtype CSR
    typedef struct packed {
        logic        vill;
        logic [22:0] reserved;
        logic        vma;
        logic        vta;
        vsew_e       vsew;
        vlmul_e      vlmul;
    } vtype_t;

    typedef struct packed {
        logic [VLEN-1:0] first;
        logic [VLEN-1:0] second;
    } vec_operands_t;

    localparam vtype_t VTYPE_VILL = '{
        vill:     1'b1,
        reserved: 23'd0,
        vma:      1'b0,
        vta:      1'b0,
        vsew:     EW8,
        vlmul:    LMUL_1
    };

endpackage

//--- src/vec_csrs.sv
module vec_csrs (
    input  logic                       clk,
    input  logic                       reset_n,
    input  vec_pkg::vec_op_e           vector_operation_i,
    input  logic [31:0]                avl_i,
    input  logic [10:0]                zimm_i,
    input  logic [4:0]                 rs1_i,
    input  logic [4:0]                 rd_i,
    output vec_pkg::vtype_t            vtype_o,
    output logic [vec_pkg::VL_W-1:0]   vl_o,
    output logic [vec_pkg::VL_W-1:0]   vl_next_o
);

    import vec_pkg::*;

    logic            is_vset;
    logic            bad_enc;
    logic            rsvd_set;
    vsew_e           new_sew;
    vlmul_e          new_lmul;
    logic [VL_W-1:0] vlmax;
    logic [31:0]     avl;
    vtype_t          vtype_next;

    assign is_vset  = vector_operation_i inside {VSETVLI, VSETIVLI};
    assign new_lmul = vlmul_e'(zimm_i[2:0]);
    assign new_sew  = vsew_e'(zimm_i[5:3]);

    // vsetivli carries only a 10-bit zimm
    assign rsvd_set = (vector_operation_i == VSETIVLI) ? (zimm_i[9:8] != 2'b00)
                                                       : (zimm_i[10:8] != 3'b000);

    assign bad_enc = rsvd_set
                  || !(new_sew inside {EW8, EW16, EW32})
                  || !(new_lmul inside {LMUL_1, LMUL_2, LMUL_4, LMUL_8});

    // VLEN * LMUL / SEW
    assign vlmax = (VL_W'(VLENB) << new_lmul[1:0]) >> new_sew[1:0];

    assign avl = (vector_operation_i == VSETIVLI) ? {27'd0, rs1_i} : avl_i;

    always_comb begin
        if (bad_enc) begin
            vl_next_o = '0;
        end else if (vector_operation_i == VSETVLI && rs1_i == 5'd0 && rd_i != 5'd0) begin
            vl_next_o = vlmax;
        end else if (vector_operation_i == VSETVLI && rs1_i == 5'd0) begin
            vl_next_o = vl_o;
        end else if (avl < 32'(vlmax)) begin
            vl_next_o = VL_W'(avl);
        end else begin
            vl_next_o = vlmax;
        end
    end

    always_comb begin
        vtype_next = VTYPE_VILL;
        if (!bad_enc) begin
            vtype_next.vill  = 1'b0;
            vtype_next.vma   = zimm_i[7];
            vtype_next.vta   = zimm_i[6];
            vtype_next.vsew  = new_sew;
            vtype_next.vlmul = new_lmul;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vl_o    <= '0;
            vtype_o <= VTYPE_VILL;
        end else if (is_vset) begin
            vl_o    <= vl_next_o;
            vtype_o <= vtype_next;
        end
    end

endmodule

//--- src/vec_regbank.sv
module vec_regbank (
    input  logic                       clk,
    input  logic [4:0]                 vs1_addr_i,
    input  logic [4:0]                 vs2_addr_i,
    input  logic [4:0]                 vd_addr_i,
    input  logic [vec_pkg::VLENB-1:0]  wr_be_i,
    input  logic [vec_pkg::VLEN-1:0]   vd_data_i,
    output logic [vec_pkg::VLEN-1:0]   vs1_data_o,
    output logic [vec_pkg::VLEN-1:0]   vs2_data_o
);

    import vec_pkg::*;

    logic [VLEN-1:0] regs [32];

    // One enable per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < VLENB; b++) begin
            if (wr_be_i[b]) begin
                regs[vd_addr_i][b*8 +: 8] <= vd_data_i[b*8 +: 8];
            end
        end
    end

    assign vs1_data_o = regs[vs1_addr_i];
    assign vs2_data_o = regs[vs2_addr_i];

endmodule

//--- src/vec_alu.sv
module vec_alu (
    input  logic                       clk,
    input  logic                       reset_n,
    input  vec_pkg::vec_operands_t     operands_i,
    input  vec_pkg::vec_op_e           operation_i,
    input  vec_pkg::vsew_e             vsew_i,
    output logic [vec_pkg::VLEN-1:0]   result_o
);

    import vec_pkg::*;

    logic [VLEN-1:0] result_next;

    // Lane arithmetic on operands widened to 32 bits
    function automatic logic [31:0] lane_op(
        input vec_op_e     op,
        input logic [31:0] a_s,
        input logic [31:0] a_z,
        input logic [31:0] b_s,
        input logic [4:0]  shamt
    );
        logic [31:0] r;
        case (op)
            VADD:             r = a_s + b_s;
            VSUB:             r = a_s - b_s;
            VAND:             r = a_s & b_s;
            VOR:              r = a_s | b_s;
            VXOR:             r = a_s ^ b_s;
            VMIN:             r = ($signed(a_s) < $signed(b_s)) ? a_s : b_s;
            VMAX:             r = ($signed(a_s) < $signed(b_s)) ? b_s : a_s;
            VSLL:             r = a_z << shamt;
            VSRL:             r = a_z >> shamt;
            VMV_V, VMV_S_X:   r = b_s;
            VMV_X_S:          r = a_s;
            default:          r = '0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // One lane array per SEW
    ////////////////////////////////////////

    for (genvar w = 0; w < 3; w++) begin : g_sew
        logic [VLEN-1:0] res;

        for (genvar l = 0; l < VLEN / (8 << w); l++) begin : g_lane
            logic [(8<<w)-1:0] a;
            logic [(8<<w)-1:0] b;
            logic [4:0]        shamt;
            logic [31:0]       r;

            assign a = operands_i.first[l*(8<<w) +: (8<<w)];
            assign b = operands_i.second[l*(8<<w) +: (8<<w)];

            // Only log2(SEW) bits of the shift amount count
            assign shamt = 5'(b[$clog2(8<<w)-1:0]);

            assign r = lane_op(operation_i, 32'(signed'(a)), 32'(a),
                               32'(signed'(b)), shamt);

            assign res[l*(8<<w) +: (8<<w)] = r[(8<<w)-1:0];
        end
    end

    always_comb begin
        case (vsew_i)
            EW8:     result_next = g_sew[0].res;
            EW16:    result_next = g_sew[1].res;
            default: result_next = g_sew[2].res;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else begin
            result_o <= result_next;
        end
    end

endmodule

//--- src/vector_unit.sv
module vector_unit (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [31:0]        instruction_i,
    input  vec_pkg::vec_op_e   vector_operation_i,
    input  logic [31:0]        op1_scalar_i,
    // Reserved for vsetvl, not decoded here
    input  logic [31:0]        op2_scalar_i,
    output logic               hold_o,
    output vec_pkg::vtype_t    vtype_o,
    output logic [31:0]        res_scalar_o,
    output logic               wr_en_scalar_o
);

    import vec_pkg::*;

    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [2:0]       funct3;
    logic [10:0]      zimm;
    op_cat_e          op_cat;

    vtype_t           vtype;
    logic [VL_W-1:0]  vl;
    logic [VL_W-1:0]  vl_next;

    vec_state_e       state;
    vec_state_e       next_state;
    logic [2:0]       grp_cnt;
    logic [2:0]       grp_last;
    logic             drain_cnt;
    logic             is_vset;
    logic             is_single;
    logic             start;
    logic             is_xs_r;
    logic             xs_done;

    logic [4:0]       vs1_addr;
    logic [4:0]       vs2_addr;
    logic [VLEN-1:0]  vs1_data;
    logic [VLEN-1:0]  vs2_data;
    logic [VLEN-1:0]  scalar_rep;
    logic [VLEN-1:0]  imm_rep;
    vec_operands_t    operands;
    logic [VLEN-1:0]  alu_result;

    logic [VLENB-1:0] tail_be;
    logic [VLENB-1:0] be_s1;
    logic [VLENB-1:0] be_s2;
    logic [4:0]       wr_addr_s1;
    logic [4:0]       wr_addr_s2;
    logic [31:0]      elem0_sext;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1    = instruction_i[19:15];
    assign rs2    = instruction_i[24:20];
    assign zimm   = instruction_i[30:20];
    assign op_cat = op_cat_e'(funct3);

    assign is_vset   = vector_operation_i inside {VSETVLI, VSETIVLI};
    assign is_single = vector_operation_i inside {VMV_S_X, VMV_X_S};
    assign start     = (state == V_IDLE) && (vector_operation_i != VNOP) && !is_vset;

    vec_csrs i_vec_csrs (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .avl_i              (op1_scalar_i),
        .zimm_i             (zimm),
        .rs1_i              (rs1),
        .rd_i               (rd),
        .vtype_o            (vtype),
        .vl_o               (vl),
        .vl_next_o          (vl_next)
    );

    assign vtype_o = vtype;

    ////////////////////////////////////////
    // Group sequencer
    ////////////////////////////////////////

    always_comb begin
        if (is_single) begin
            grp_last = 3'd0;
        end else begin
            case (vtype.vlmul)
                LMUL_2:  grp_last = 3'd1;
                LMUL_4:  grp_last = 3'd3;
                LMUL_8:  grp_last = 3'd7;
                default: grp_last = 3'd0;
            endcase
        end
    end

    always_comb begin
        case (state)
            V_IDLE:  next_state = start ? V_EXEC : V_IDLE;
            V_EXEC:  next_state = (grp_cnt == grp_last) ? V_DRAIN : V_EXEC;
            V_DRAIN: next_state = drain_cnt ? V_IDLE : V_DRAIN;
            default: next_state = V_IDLE;
        endcase
    end

    // Low again in the last drain cycle
    assign hold_o = (next_state != V_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= V_IDLE;
            grp_cnt   <= '0;
            drain_cnt <= 1'b0;
            is_xs_r   <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                V_IDLE: begin
                    grp_cnt   <= '0;
                    drain_cnt <= 1'b0;
                    if (start) begin
                        is_xs_r <= (vector_operation_i == VMV_X_S);
                    end
                end
                V_EXEC: begin
                    if (grp_cnt != grp_last) begin
                        grp_cnt <= grp_cnt + 3'd1;
                    end
                end
                V_DRAIN: drain_cnt <= drain_cnt + 1'b1;
                default: grp_cnt <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Register bank and write pipeline
    ////////////////////////////////////////

    assign vs1_addr = rs1 + 5'(grp_cnt);
    assign vs2_addr = rs2 + 5'(grp_cnt);

    // Byte enables for the register read this cycle
    always_comb begin
        logic [VL_W-1:0] elem_idx;
        tail_be = '0;
        for (int i = 0; i < VLENB; i++) begin
            elem_idx = VL_W'(grp_cnt) * (VL_W'(VLENB) >> vtype.vsew[1:0])
                     + (VL_W'(i) >> vtype.vsew[1:0]);
            if (vector_operation_i == VMV_S_X) begin
                tail_be[i] = (elem_idx == '0) && (vl != '0);
            end else if (vector_operation_i != VMV_X_S) begin
                tail_be[i] = (elem_idx < vl);
            end
        end
    end

    // Two stages to meet the ALU result
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            be_s1 <= '0;
            be_s2 <= '0;
        end else begin
            be_s1 <= (state == V_EXEC) ? tail_be : '0;
            be_s2 <= be_s1;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_s1 <= rd + 5'(grp_cnt);
        wr_addr_s2 <= wr_addr_s1;
    end

    vec_regbank i_vec_regbank (
        .clk        (clk),
        .vs1_addr_i (vs1_addr),
        .vs2_addr_i (vs2_addr),
        .vd_addr_i  (wr_addr_s2),
        .wr_be_i    (be_s2),
        .vd_data_i  (alu_result),
        .vs1_data_o (vs1_data),
        .vs2_data_o (vs2_data)
    );

    ////////////////////////////////////////
    // Operands
    ////////////////////////////////////////

    always_comb begin
        case (vtype.vsew)
            EW8:     scalar_rep = {(VLENB){op1_scalar_i[7:0]}};
            EW16:    scalar_rep = {(VLENB/2){op1_scalar_i[15:0]}};
            default: scalar_rep = {(VLENB/4){op1_scalar_i}};
        endcase
    end

    // Shift amounts are unsigned, everything else sign-extends
    always_comb begin
        if (vector_operation_i inside {VSLL, VSRL}) begin
            case (vtype.vsew)
                EW8:     imm_rep = {(VLENB){3'd0, rs1}};
                EW16:    imm_rep = {(VLENB/2){11'd0, rs1}};
                default: imm_rep = {(VLENB/4){27'd0, rs1}};
            endcase
        end else begin
            case (vtype.vsew)
                EW8:     imm_rep = {(VLENB){{3{rs1[4]}}, rs1}};
                EW16:    imm_rep = {(VLENB/2){{11{rs1[4]}}, rs1}};
                default: imm_rep = {(VLENB/4){{27{rs1[4]}}, rs1}};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == V_EXEC) begin
            operands.first <= vs2_data;
            case (op_cat)
                OPIVX, OPMVX: operands.second <= scalar_rep;
                OPIVI:        operands.second <= imm_rep;
                default:      operands.second <= vs1_data;
            endcase
        end
    end

    vec_alu i_vec_alu (
        .clk         (clk),
        .reset_n     (reset_n),
        .operands_i  (operands),
        .operation_i (vector_operation_i),
        .vsew_i      (vtype.vsew),
        .result_o    (alu_result)
    );

    ////////////////////////////////////////
    // Scalar result
    ////////////////////////////////////////

    always_comb begin
        case (vtype.vsew)
            EW8:     elem0_sext = {{24{alu_result[7]}}, alu_result[7:0]};
            EW16:    elem0_sext = {{16{alu_result[15]}}, alu_result[15:0]};
            default: elem0_sext = alu_result[31:0];
        endcase
    end

    // vmv.x.s result leaves the ALU in the last drain cycle
    assign xs_done = (state == V_DRAIN) && drain_cnt && is_xs_r;

    assign res_scalar_o   = is_vset ? 32'(vl_next) : elem0_sext;
    assign wr_en_scalar_o = is_vset || xs_done;

endmodule

//--- dv/tb_vector_unit.sv
module tb_vector_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import vec_pkg::*;

    localparam int MAX_RECS     = 100;
    localparam int REC_WORDS    = 5;
    localparam int HOLD_TIMEOUT = 64;

    logic        clk = 1'b0;
    logic        reset_n;
    logic [31:0] instruction;
    vec_op_e     operation;
    logic [31:0] op1_scalar;
    logic [31:0] op2_scalar;
    logic        hold;
    vtype_t      vtype;
    logic [31:0] res_scalar;
    logic        wr_en_scalar;

    // Five words per record: instruction, op, op1, expected, flag
    logic [31:0] test_words [512];
    int          rec_idx;
    logic [2:0]  lmul_sel;

    always #10 clk = ~clk;

    vector_unit i_vector_unit (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction),
        .vector_operation_i (operation),
        .op1_scalar_i       (op1_scalar),
        .op2_scalar_i       (op2_scalar),
        .hold_o             (hold),
        .vtype_o            (vtype),
        .res_scalar_o       (res_scalar),
        .wr_en_scalar_o     (wr_en_scalar)
    );

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h (record %0d)", name, got, exp, rec_idx);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] record_word(input logic [8:0] base, input logic [2:0] col);
        return test_words[base + 9'(col)];
    endfunction

    ////////////////////////////////////////
    // Instruction handling
    ////////////////////////////////////////

    // No hold, new vl on the scalar side in the same cycle
    task automatic issue_vset(input logic [31:0] expected, input logic check_res);
        @(negedge clk);
        check_equal("hold_o", 32'(hold), 32'd0);
        check_equal("wr_en_scalar_o", 32'(wr_en_scalar), 32'd1);
        if (check_res) begin
            check_equal("res_scalar_o", res_scalar, expected);
        end
        lmul_sel = instruction[22:20];
        @(posedge clk);
        #1;
        // vtype takes the low zimm fields
        check_equal("vtype_o", vtype, {24'd0, instruction[27:20]});
    endtask

    task automatic execute_element(input logic [31:0] expected, input logic check_res);
        int hold_cycles;
        int group_regs;
        hold_cycles = 0;
        if (operation inside {VMV_S_X, VMV_X_S}) begin
            group_regs = 1;
        end else begin
            group_regs = 1 << lmul_sel;
        end
        @(negedge clk);
        while (hold) begin
            hold_cycles++;
            check_equal("wr_en_scalar_o", 32'(wr_en_scalar), 32'd0);
            if (hold_cycles >= HOLD_TIMEOUT) begin
                $display("Timeout: hold_o still high after %0d cycles in record %0d",
                         hold_cycles, rec_idx);
                end_with_failure();
            end
            @(negedge clk);
        end
        check_equal("hold_o cycles", hold_cycles, group_regs + 2);
        // Cycle where hold has fallen
        if (operation == VMV_X_S) begin
            check_equal("wr_en_scalar_o", 32'(wr_en_scalar), 32'd1);
            if (check_res) begin
                check_equal("res_scalar_o", res_scalar, expected);
            end
        end else begin
            check_equal("wr_en_scalar_o", 32'(wr_en_scalar), 32'd0);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [8:0]  base;
        logic [31:0] flag;
        logic [31:0] op_word;
        logic        found_end;
        reset_n     = 1'b0;
        instruction = '0;
        operation   = VNOP;
        op1_scalar  = '0;
        op2_scalar  = '0;
        lmul_sel    = '0;
        rec_idx     = 0;
        found_end   = 1'b0;
        $readmemh("dv/vec_testdata.hex", test_words);

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);
        check_equal("hold_o", 32'(hold), 32'd0);
        check_equal("wr_en_scalar_o", 32'(wr_en_scalar), 32'd0);
        check_equal("vtype_o.vill", 32'(vtype.vill), 32'd1);
        @(posedge clk);
        #1;

        // Each record starts 1 ns after a rising edge
        for (int r = 0; r < MAX_RECS && !found_end; r++) begin
            rec_idx = r;
            base    = 9'(r * REC_WORDS);
            flag    = record_word(base, 3'd4);
            if (flag == 32'd2) begin
                found_end = 1'b1;
            end else begin
                instruction = record_word(base, 3'd0);
                op_word     = record_word(base, 3'd1);
                operation   = vec_op_e'(op_word[3:0]);
                op1_scalar  = record_word(base, 3'd2);
                if (operation inside {VSETVLI, VSETIVLI}) begin
                    issue_vset(record_word(base, 3'd3), flag[0]);
                end else begin
                    execute_element(record_word(base, 3'd3), flag[0]);
                end
            end
        end
        operation = VNOP;

        if (found_end) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test data ended without an end record");
            end_with_failure();
        end
    end

endmodule

//--- dv/vec_testdata.hex
// instruction op op1 expected flag
// flag 0 no scalar check, 1 check scalar result, 2 end of data
// vsetvli and vsetivli
000372d7 1 0000000a 00000008 1
04a072d7 1 00000003 00000010 1
01107057 1 00000000 00000010 1
c131f2d7 2 00000000 00000003 1
c00a72d7 2 00000000 00000008 1
// SEW 8, v1 and v2 splatted
5e0540d7 c 000000f3 00000000 0
5e02b157 c 00000000 00000000 0
021101d7 3 00000000 00000000 0
423023d7 e 00000000 fffffff8 1
0a25c257 4 00000007 00000000 0
424023d7 e 00000000 fffffffe 1
1e1eb2d7 9 00000000 00000000 0
425023d7 e 00000000 fffffffd 1
a2123357 b 00000000 00000000 0
426023d7 e 00000000 0000000f 1
// SEW 16
008372d7 1 00000004 00000004 1
2e1103d7 7 00000000 00000000 0
427023d7 e 00000000 fffff6f6 1
96264457 a 00000013 00000000 0
428023d7 e 00000000 00002828 1
1616c4d7 8 ffff8000 00000000 0
429023d7 e 00000000 ffff8000 1
// SEW 32
c10172d7 2 00000000 00000002 1
2617b557 5 00000000 00000000 0
42a023d7 e 00000000 00000003 1
2a2745d7 6 80000000 00000000 0
42b023d7 e 00000000 85050505 1
4207e657 d 12345678 00000000 0
42c023d7 e 00000000 12345678 1
// Tail, SEW 16 LMUL 4 with vl 5
00a072d7 1 00000000 00000010 1
5e0fb857 c 00000000 00000000 0
00a372d7 1 00000005 00000005 1
03013857 3 00000000 00000000 0
431023d7 e 00000000 00000001 1
432023d7 e 00000000 ffffffff 1
// End of data
00000000 0 00000000 00000000 2

//--- sim.f
src/vec_pkg.sv
src/vec_csrs.sv
src/vec_regbank.sv
src/vec_alu.sv
src/vector_unit.sv
dv/tb_vector_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vector_unit
RTL_TOP   ?= vector_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= src/vec_pkg.sv src/vec_csrs.sv src/vec_regbank.sv src/vec_alu.sv \
             src/vector_unit.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
